// ==== design/rx_capture_pkg.sv ====
package rx_capture_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////
  localparam int NUM_LANES        = 4;   // receive lanes, also bits per sample
  localparam int LANE_BITS        = 64;  // user data bits per lane per clk
  localparam int WORD_BITS        = 32;  // host read word
  localparam int WORDS_PER_ENTRY  = 8;   // read words per 256-bit group
  localparam int SAMPLES_PER_WORD = WORD_BITS / NUM_LANES;
  localparam int WORD_IDX_W       = $clog2(WORDS_PER_ENTRY);
  localparam int FIFO_DEPTH       = 16;  // power of two, pointers wrap
  localparam int FIFO_PTR_W       = $clog2(FIFO_DEPTH);

  // prbs15, x^15 + x^14 + 1
  localparam int PRBS_LEN = 15;
  localparam int PRBS_TAP = 14;
  localparam logic [PRBS_LEN-1:0] PRBS_SEED = '1; // state right after a sync

  typedef struct packed {
    logic [LANE_BITS-1:0] lane3;  // also carries the match pattern in 31:0
    logic [LANE_BITS-1:0] lane2;
    logic [LANE_BITS-1:0] lane1;
    logic [LANE_BITS-1:0] lane0;
  } lane_words_t;

  // ascending index so word[0] sits in the top 32 bits and is read first
  typedef struct packed {
    logic [0:WORDS_PER_ENTRY-1][WORD_BITS-1:0] word;
  } sample_group_t;

  // sample g = {lane3[g], lane2[g], lane0[g], lane1[g]}
  // word k holds samples 8k+7 (top nibble) down to 8k
  function automatic sample_group_t interleave(lane_words_t l);
    sample_group_t g;
    for (int s = 0; s < LANE_BITS; s++) begin
      g.word[s / SAMPLES_PER_WORD][NUM_LANES*(s % SAMPLES_PER_WORD) +: NUM_LANES] =
        {l.lane3[s], l.lane2[s], l.lane0[s], l.lane1[s]};
    end
    return g;
  endfunction

endpackage

// ==== design/prbs15_gen.sv ====
`timescale 1ns/1ps

module prbs15_gen import rx_capture_pkg::*; (
  input  logic                 clk100,
  input  logic                 rst_n,
  input  logic                 sync,      // reload seed, next word is word 0
  output logic [LANE_BITS-1:0] prbs_word
);

  logic [PRBS_LEN-1:0] state;       // lfsr state between clk cycles
  logic [PRBS_LEN-1:0] state_next;  // state after 64 steps
  logic                fb;          // feedback bit of one step

  //////////////////////////////////////////////////////////////////////
  // unrolled lfsr, 64 steps per clk
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    state_next = state;
    fb         = 1'b0;
    prbs_word  = '0;
    for (int i = LANE_BITS - 1; i >= 0; i--) begin
      fb           = state_next[PRBS_LEN-1] ^ state_next[PRBS_TAP-1];
      prbs_word[i] = fb;                              // first bit lands in msb
      state_next   = {state_next[PRBS_LEN-2:0], fb};  // shift left, new bit in lsb
    end
  end

  // word seen in the cycle after sync is the first word from seed
  always_ff @(posedge clk100) begin
    if (!rst_n) begin
      state <= PRBS_SEED;
    end else if (sync) begin
      state <= PRBS_SEED;      // restart sequence
    end else begin
      state <= state_next;     // free running
    end
  end

endmodule

// ==== design/lane_descrambler.sv ====
`timescale 1ns/1ps

module lane_descrambler import rx_capture_pkg::*; (
  input  logic          clk100,
  input  logic          rst_n,
  input  lane_words_t   lanes,          // raw lane words, one set per clk
  input  logic          lane_valid,     // lanes carry data this clk
  input  logic          xor_on,         // descramble with local prbs
  input  logic [31:0]   match_pattern,  // sync word expected on lane3
  output sample_group_t samples,        // interleaved group, registered
  output logic          wr              // write strobe for the fifo
);

  logic                 prbs_sync;  // lane3 carries the match pattern
  logic [LANE_BITS-1:0] prbs_word;  // current prbs word
  lane_words_t          descr;      // lanes after optional xor

  //////////////////////////////////////////////////////////////////////
  // prbs alignment
  //////////////////////////////////////////////////////////////////////

  // only the low 32 bits of lane3 are compared
  assign prbs_sync = (lanes.lane3[31:0] == match_pattern);

  prbs15_gen prbs_i (
    .clk100    (clk100),
    .rst_n     (rst_n),
    .sync      (prbs_sync),
    .prbs_word (prbs_word)
  );

  //////////////////////////////////////////////////////////////////////
  // descramble
  //////////////////////////////////////////////////////////////////////

  // every lane is xored with the same word, lanes are assumed aligned
  always_comb begin
    descr = lanes;
    if (xor_on) begin
      descr.lane3 = lanes.lane3 ^ prbs_word;
      descr.lane2 = lanes.lane2 ^ prbs_word;
      descr.lane1 = lanes.lane1 ^ prbs_word;
      descr.lane0 = lanes.lane0 ^ prbs_word;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // interleave and register
  //////////////////////////////////////////////////////////////////////

  // group lands in the fifo entry with samples 7..0 in the top word
  always_ff @(posedge clk100) begin
    samples <= interleave(descr);  // payload, no reset
  end

  // wr follows lane_valid by one clk, aligned with samples
  always_ff @(posedge clk100) begin
    if (!rst_n) begin
      wr <= 1'b0;
    end else begin
      wr <= lane_valid;
    end
  end

endmodule

// ==== design/slip_pulse_gen.sv ====
`timescale 1ns/1ps

module slip_pulse_gen import rx_capture_pkg::*; (
  input  logic                 clk100,
  input  logic                 rst_n,
  input  logic [1:0]           chan_sel,          // target channel
  input  logic                 gearbox_slip,      // host level
  input  logic                 rxslide,           // host level
  output logic [NUM_LANES-1:0] gearbox_slip_vec,  // one clk pulse per rise
  output logic [NUM_LANES-1:0] rxslide_vec        // two clk pulse per rise
);

  logic                 slip_q1, slip_q2;               // slip level history
  logic                 slide_q1, slide_q2, slide_q3;   // slide level history
  logic [1:0]           chan_q;                         // registered chan_sel
  logic                 slip_rise;
  logic                 slide_pulse;
  logic [NUM_LANES-1:0] chan_onehot;

  assign slip_rise   = slip_q1 & ~slip_q2;
  // rise seen in either of the last two clks, so always two wide
  assign slide_pulse = (slide_q1 & ~slide_q2) | (slide_q2 & ~slide_q3);
  assign chan_onehot = NUM_LANES'(1) << chan_q;

  always_ff @(posedge clk100) begin
    if (!rst_n) begin
      {slip_q1, slip_q2}            <= '0;
      {slide_q1, slide_q2, slide_q3} <= '0;
      chan_q           <= '0;
      gearbox_slip_vec <= '0;
      rxslide_vec      <= '0;
    end else begin
      {slip_q1, slip_q2}             <= {gearbox_slip, slip_q1};
      {slide_q1, slide_q2, slide_q3} <= {rxslide, slide_q1, slide_q2};
      chan_q           <= chan_sel;
      gearbox_slip_vec <= slip_rise ? chan_onehot : '0;    // steer to one channel
      rxslide_vec      <= slide_pulse ? chan_onehot : '0;
    end
  end

endmodule

// ==== design/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo import rx_capture_pkg::*; #(
  parameter type payload_t = logic
) (
  input  logic     clk100,
  input  logic     rst_n,
  input  logic     clr,    // synchronous flush
  input  payload_t din,
  input  logic     wr,     // dropped while full
  input  logic     pop,    // ignored while empty
  output payload_t dout,   // head entry, valid while empty is low
  output logic     full,
  output logic     empty
);

  payload_t              mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_PTR_W:0]   count;   // one extra bit to tell full from empty
  logic                  do_wr;
  logic                  do_pop;

  //////////////////////////////////////////////////////////////////////
  // flags and qualified strobes
  //////////////////////////////////////////////////////////////////////
  assign full   = (count == (FIFO_PTR_W+1)'(FIFO_DEPTH));
  assign empty  = (count == '0);
  assign do_wr  = wr & ~full;
  assign do_pop = pop & ~empty;

  // head is read straight from the array, a write shows up after its edge
  assign dout = mem[rd_ptr];

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk100) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pointers and occupancy
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk100) begin
    if (!rst_n || clr) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;   // wraps, depth is a power of two
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;     // both or neither
      endcase
    end
  end

endmodule

// ==== design/word_unpacker.sv ====
`timescale 1ns/1ps

module word_unpacker import rx_capture_pkg::*; (
  input  logic                 clk100,
  input  logic                 rst_n,
  input  logic                 clr,         // flush together with the fifo
  input  sample_group_t        head,        // fifo head entry
  input  logic                 fifo_empty,
  output logic                 pop,         // take head into the holding reg
  input  logic                 rd,          // host read level
  output logic [WORD_BITS-1:0] data_out,    // current word
  output logic                 empty        // nothing to read
);

  sample_group_t         held;       // entry being read out
  logic [WORD_IDX_W-1:0] idx;        // next word to hand out
  logic                  loaded;     // held is valid
  logic                  rd_q1;
  logic                  rd_q2;
  logic                  advance;    // host consumed the current word
  logic                  last_done;  // last word of held consumed

  //////////////////////////////////////////////////////////////////////
  // read edge detect
  //////////////////////////////////////////////////////////////////////

  // rise seen at one edge, word moves on at the next
  assign advance   = rd_q1 & ~rd_q2 & loaded;      // ignored while empty
  assign last_done = advance & (idx == WORD_IDX_W'(WORDS_PER_ENTRY - 1));
  assign pop       = ~clr & ~fifo_empty & (~loaded | last_done);

  assign empty    = ~loaded;
  assign data_out = held.word[idx];  // word 0 is the msb word of the entry

  //////////////////////////////////////////////////////////////////////
  // holding register and word index
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk100) begin
    if (pop) begin
      held <= head;  // payload, no reset
    end
  end

  always_ff @(posedge clk100) begin
    if (!rst_n) begin
      rd_q1  <= 1'b0;
      rd_q2  <= 1'b0;
      idx    <= '0;
      loaded <= 1'b0;
    end else begin
      rd_q1 <= rd;
      rd_q2 <= rd_q1;
      if (clr) begin
        idx    <= '0;
        loaded <= 1'b0;
      end else if (pop) begin
        idx    <= '0;          // fresh entry starts at word 0
        loaded <= 1'b1;
      end else if (last_done) begin
        loaded <= 1'b0;        // fifo ran dry
      end else if (advance) begin
        idx <= idx + 1'b1;
      end
    end
  end

endmodule

// ==== design/rx_capture_top.sv ====
`timescale 1ns/1ps

module rx_capture_top import rx_capture_pkg::*; (
  input  logic                 clk100,
  input  logic                 rst_n,
  input  lane_words_t          lanes,
  input  logic                 lane_valid,
  input  logic                 xor_on,
  input  logic [31:0]          match_pattern,
  input  logic [1:0]           chan_sel,
  input  logic                 gearbox_slip,
  input  logic                 rxslide,
  input  logic                 fifo_reset,        // sync flush of fifo and unpacker
  input  logic                 rd,
  output logic [NUM_LANES-1:0] gearbox_slip_vec,
  output logic [NUM_LANES-1:0] rxslide_vec,
  output logic [WORD_BITS-1:0] data_out,
  output logic                 full,
  output logic                 empty
);

  sample_group_t samples;     // descrambler to fifo
  logic          wr;
  sample_group_t fifo_head;   // fifo to unpacker
  logic          fifo_empty;
  logic          pop;

  //////////////////////////////////////////////////////////////////////
  // capture path
  //////////////////////////////////////////////////////////////////////
  lane_descrambler descr_i (
    .clk100        (clk100),
    .rst_n         (rst_n),
    .lanes         (lanes),
    .lane_valid    (lane_valid),
    .xor_on        (xor_on),
    .match_pattern (match_pattern),
    .samples       (samples),
    .wr            (wr)
  );

  sample_fifo #(.payload_t(sample_group_t)) fifo_i (
    .clk100 (clk100),
    .rst_n  (rst_n),
    .clr    (fifo_reset),
    .din    (samples),
    .wr     (wr),
    .pop    (pop),
    .dout   (fifo_head),
    .full   (full),
    .empty  (fifo_empty)
  );

  word_unpacker unpack_i (
    .clk100     (clk100),
    .rst_n      (rst_n),
    .clr        (fifo_reset),
    .head       (fifo_head),
    .fifo_empty (fifo_empty),
    .pop        (pop),
    .rd         (rd),
    .data_out   (data_out),
    .empty      (empty)
  );

  // transceiver slip controls
  slip_pulse_gen slip_i (
    .clk100           (clk100),
    .rst_n            (rst_n),
    .chan_sel         (chan_sel),
    .gearbox_slip     (gearbox_slip),
    .rxslide          (rxslide),
    .gearbox_slip_vec (gearbox_slip_vec),
    .rxslide_vec      (rxslide_vec)
  );

endmodule

// ==== verification/rx_capture_chk.sv ====
`timescale 1ns/1ps

module rx_capture_chk import rx_capture_pkg::*; (
  input logic                 clk100,
  input logic                 rst_n,
  input logic                 gearbox_slip,
  input logic                 rxslide,
  input logic [NUM_LANES-1:0] gearbox_slip_vec,
  input logic [NUM_LANES-1:0] rxslide_vec,
  input logic                 full,
  input logic                 empty
);

  int unsigned fail_cnt = 0;  // assertion failures so far

  //////////////////////////////////////////////////////////////////////
  // buffer flags
  //////////////////////////////////////////////////////////////////////
  assert property (@(posedge clk100) disable iff (!rst_n) !(full && empty))
    else begin
      $error("full and empty are high together");
      fail_cnt++;
    end

  //////////////////////////////////////////////////////////////////////
  // slip and slide pulses
  //////////////////////////////////////////////////////////////////////
  assert property (@(posedge clk100) disable iff (!rst_n)
    (|gearbox_slip_vec) |=> (gearbox_slip_vec == '0))  // one clk wide
    else begin
      $error("gearbox_slip_vec pulse is longer than one cycle");
      fail_cnt++;
    end

  assert property (@(posedge clk100) disable iff (!rst_n)
    $rose(|rxslide_vec) |=> (|rxslide_vec) ##1 (rxslide_vec == '0))  // two clks wide
    else begin
      $error("rxslide_vec pulse is not two cycles long");
      fail_cnt++;
    end

  assert property (@(posedge clk100) disable iff (!rst_n)
    $onehot0(gearbox_slip_vec) && $onehot0(rxslide_vec))
    else begin
      $error("slip or slide vector drives more than one channel");
      fail_cnt++;
    end

  // input rise seen two clks earlier, slide also three clks earlier
  assert property (@(posedge clk100) disable iff (!rst_n)
    (|gearbox_slip_vec) |-> ($past(gearbox_slip, 2) && !$past(gearbox_slip, 3)))
    else begin
      $error("gearbox_slip_vec pulsed without a rising gearbox_slip");
      fail_cnt++;
    end

  assert property (@(posedge clk100) disable iff (!rst_n)
    (|rxslide_vec) |-> (($past(rxslide, 2) && !$past(rxslide, 3)) ||
                        ($past(rxslide, 3) && !$past(rxslide, 4))))
    else begin
      $error("rxslide_vec pulsed without a rising rxslide");
      fail_cnt++;
    end

endmodule

bind rx_capture_top rx_capture_chk chk_i (.*);

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk100,  // 40 ns period
  output logic rst_n    // low for the first 5 cycles
);

  localparam int HALF_PERIOD = 20;
  localparam int RESET_CYCLES = 5;

  initial begin
    clk100 = 1'b0;
    forever #HALF_PERIOD clk100 = ~clk100;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk100);
    rst_n <= 1'b1;  // release on an edge, like the other inputs
  end

endmodule

// ==== verification/rx_capture_tb.sv ====
`timescale 1ns/1ps

module rx_capture_tb import rx_capture_pkg::*; ();

  //////////////////////////////////////////////////////////////////////
  // run length and timeout
  //////////////////////////////////////////////////////////////////////
  localparam logic [31:0] MATCH_PATTERN = 32'hc3a5_0f96;
  localparam int RAW_GROUPS   = 6;
  localparam int PRBS_GROUPS  = 4;
  localparam int OVER_GROUPS  = FIFO_DEPTH + 3;  // three more than fit
  localparam int FILL_GROUPS  = FIFO_DEPTH + 2;  // fills fifo and unpacker before the flush
  localparam int FLUSH_GROUPS = 3;
  localparam int WORD_CYCLES  = 4;               // wait, rd high, rd low, advance
  localparam int READ_GROUPS  = RAW_GROUPS + PRBS_GROUPS + FIFO_DEPTH + 1 + FLUSH_GROUPS;
  localparam int RUN_CYCLES   = 20 + READ_GROUPS * WORDS_PER_ENTRY * WORD_CYCLES
                                + OVER_GROUPS + FILL_GROUPS + 2 * FLUSH_GROUPS
                                + NUM_LANES * 10;
  localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES;  // margin

  logic                 clk100, rst_n;
  lane_words_t          lanes;
  logic                 lane_valid, xor_on, gearbox_slip, rxslide, fifo_reset, rd;
  logic [31:0]          match_pattern;
  logic [1:0]           chan_sel;
  logic [NUM_LANES-1:0] gearbox_slip_vec, rxslide_vec;
  logic [WORD_BITS-1:0] data_out;
  logic                 full, empty;

  logic [31:0]          rand_state = 52;  // lcg seed
  logic [PRBS_LEN-1:0]  prbs_state;       // model lfsr
  logic [WORD_BITS-1:0] exp_q[$];         // expected read words in order
  int                   err_cnt = 0;
  int                   check_cnt = 0;
  int                   test_cnt = 0;
  int                   err_base = 0;     // errors before the current test
  int                   cycle_cnt = 0;

  tb_clock_gen clk_i (.clk100(clk100), .rst_n(rst_n));
  rx_capture_top dut_i (.*);

  //////////////////////////////////////////////////////////////////////
  // models
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic random_lanes(output lane_words_t l);
    for (int i = 0; i < 8; i++) begin
      rand_state = lcg_next(rand_state);
      l[32*i +: 32] = rand_state;  // 32 bits per step
    end
  endtask

  // x^15 + x^14 + 1, first bit out lands in bit 63
  task automatic prbs_word_model(output logic [LANE_BITS-1:0] w);
    logic fb;
    for (int i = LANE_BITS - 1; i >= 0; i--) begin
      fb         = prbs_state[PRBS_LEN-1] ^ prbs_state[PRBS_TAP-1];
      w[i]       = fb;
      prbs_state = {prbs_state[PRBS_LEN-2:0], fb};
    end
  endtask

  // word k, nibble j is sample 8k+j = {lane3, lane2, lane0, lane1}
  task automatic expect_group(input lane_words_t l);
    logic [WORD_BITS-1:0] w;
    int s;
    for (int k = 0; k < WORDS_PER_ENTRY; k++) begin
      for (int j = 0; j < 8; j++) begin
        s = 8 * k + j;
        w[4*j +: 4] = {l.lane3[s], l.lane2[s], l.lane0[s], l.lane1[s]};
      end
      exp_q.push_back(w);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // drive and check helpers
  //////////////////////////////////////////////////////////////////////
  task automatic push_group(input lane_words_t l);
    @(posedge clk100);
    lanes      <= l;
    lane_valid <= 1'b1;
  endtask

  task automatic stop_push();
    @(posedge clk100);
    lane_valid <= 1'b0;
  endtask

  task automatic check_value(input string name, input logic [31:0] val, input logic [31:0] exp);
    check_cnt++;
    assert (val === exp) else begin
      $display("Error: %s = %h, expected %h", name, val, exp);
      err_cnt++;
    end
  endtask

  // one word per rd rise, compared only while empty is low
  task automatic read_words(input int n);
    repeat (n) begin
      @(negedge clk100);
      while (empty) @(negedge clk100);
      check_value("data_out", data_out, exp_q.pop_front());
      @(posedge clk100);
      rd <= 1'b1;
      @(posedge clk100);
      rd <= 1'b0;
      @(posedge clk100);  // word moves on here
    end
  endtask

  function automatic int total_errors();
    return err_cnt + int'(dut_i.chk_i.fail_cnt);
  endfunction

  task automatic end_test(input string name);
    test_cnt++;
    $display("test %0d %s: %0d errors", test_cnt, name, total_errors() - err_base);
    err_base = total_errors();
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////
  initial begin
    lane_words_t          grp;
    logic [LANE_BITS-1:0] pw;
    logic [NUM_LANES-1:0] slip_seen, slide_seen;
    lanes         = '0;
    lane_valid    = 1'b0;
    xor_on        = 1'b0;
    match_pattern = MATCH_PATTERN;
    chan_sel      = 2'd0;
    gearbox_slip  = 1'b0;
    rxslide       = 1'b0;
    fifo_reset    = 1'b0;
    rd            = 1'b0;
    wait (rst_n === 1'b1);
    @(negedge clk100);
    check_value("gearbox_slip_vec", 32'(gearbox_slip_vec), 0);
    check_value("rxslide_vec", 32'(rxslide_vec), 0);
    check_value("empty", 32'(empty), 1);
    check_value("full", 32'(full), 0);
    end_test("reset state");

    repeat (RAW_GROUPS) begin
      random_lanes(grp);
      expect_group(grp);
      push_group(grp);
    end
    stop_push();
    read_words(RAW_GROUPS * WORDS_PER_ENTRY);
    end_test("raw capture");

    @(posedge clk100);
    xor_on <= 1'b1;
    lanes  <= {32'h0, MATCH_PATTERN, 192'h0};  // sync word on lane3
    prbs_state = PRBS_SEED;
    repeat (PRBS_GROUPS) begin
      prbs_word_model(pw);
      push_group({pw, pw, pw, pw});
      repeat (WORDS_PER_ENTRY) exp_q.push_back('0);  // descrambles to zero
    end
    stop_push();
    read_words(PRBS_GROUPS * WORDS_PER_ENTRY);
    @(posedge clk100);
    xor_on <= 1'b0;
    end_test("descramble");

    for (int c = 0; c < NUM_LANES; c++) begin
      @(posedge clk100);
      chan_sel <= 2'(c);
      @(posedge clk100);
      gearbox_slip <= 1'b1;
      rxslide      <= 1'b1;
      slip_seen  = '0;
      slide_seen = '0;
      repeat (6) begin              // whole pulse window
        @(negedge clk100);
        slip_seen  |= gearbox_slip_vec;
        slide_seen |= rxslide_vec;
      end
      check_value("gearbox_slip_vec", 32'(slip_seen), 32'(1) << c);
      check_value("rxslide_vec", 32'(slide_seen), 32'(1) << c);
      @(posedge clk100);
      gearbox_slip <= 1'b0;
      rxslide      <= 1'b0;
    end
    repeat (4) @(posedge clk100);
    end_test("slip and slide");

    for (int g = 0; g < OVER_GROUPS; g++) begin
      random_lanes(grp);
      if (g <= FIFO_DEPTH) expect_group(grp);  // unpacker entry plus a full fifo
      push_group(grp);
    end
    stop_push();
    @(negedge clk100);
    check_value("full", 32'(full), 1);
    read_words((FIFO_DEPTH + 1) * WORDS_PER_ENTRY);
    @(negedge clk100);
    check_value("empty", 32'(empty), 1);
    end_test("back-pressure");

    repeat (FILL_GROUPS) begin  // buffered up to full, then flushed
      random_lanes(grp);
      push_group(grp);
    end
    stop_push();
    @(posedge clk100);
    @(negedge clk100);
    check_value("full", 32'(full), 1);
    @(posedge clk100);
    fifo_reset <= 1'b1;
    @(posedge clk100);
    fifo_reset <= 1'b0;
    @(negedge clk100);
    check_value("empty", 32'(empty), 1);
    check_value("full", 32'(full), 0);
    repeat (FLUSH_GROUPS) begin
      random_lanes(grp);
      expect_group(grp);
      push_group(grp);
    end
    stop_push();
    read_words(FLUSH_GROUPS * WORDS_PER_ENTRY);
    end_test("fifo reset");

    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, total_errors());
    if (total_errors() == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog
  always @(posedge clk100) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule

// ==== list.f ====
design/rx_capture_pkg.sv
design/prbs15_gen.sv
design/lane_descrambler.sv
design/slip_pulse_gen.sv
design/sample_fifo.sv
design/word_unpacker.sv
design/rx_capture_top.sv
verification/rx_capture_chk.sv
verification/tb_clock_gen.sv
verification/rx_capture_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rx capture testbench under verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module rx_capture_tb -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vrx_capture_tb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
exit 0
